// File: fetch_pkg.sv
package fetch_pkg;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

localparam int im_addr_len = 32; // byte address into instruction memory.
localparam int im_data_len = 32; // one instruction word.

typedef logic [im_addr_len - 1:0] addr_t;
typedef logic [im_data_len - 1:0] inst_t;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

localparam addr_t reset_pc   = 32'h0000_0000;
localparam addr_t irq_vector = 32'h0000_0100; // single interrupt handler entry.

// sequential fetch advances by one word.
localparam addr_t pc_step = 32'h0000_0004;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction encodings
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

localparam logic [6:0] opcode_jal = 7'b110_1111;

// mret is matched on the whole word, no operand fields vary.
localparam inst_t inst_mret = 32'h3020_0073;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// one redirect request, only meaningful in the cycle en is high.
typedef struct packed {
    logic  en;
    addr_t addr;
} redirect_t;

// instruction handed to decode together with its address.
typedef struct packed {
    addr_t pc;
    inst_t inst;
} fetch_out_t;

endpackage

// File: ifu.sv
`timescale 1ns/1ps

module ifu (
    input  logic                  clk,
    input  logic                  rstn,
    input  fetch_pkg::redirect_t  eret,
    input  fetch_pkg::redirect_t  irq,
    input  fetch_pkg::redirect_t  ex_redirect,
    input  fetch_pkg::redirect_t  jal,
    output logic                  imem_req,
    output fetch_pkg::addr_t      imem_addr,
    input  fetch_pkg::inst_t      imem_rdata,
    input  logic                  imem_busy,
    output fetch_pkg::fetch_out_t fetch,
    output logic                  fetch_valid,
    input  logic                  stall
);

import fetch_pkg::*;

logic  started;     // low only in the first cycle out of reset.
logic  jump;
addr_t jump_addr;
addr_t req_pc;      // address of the next request to memory.
addr_t out_pc;      // pc of the next instruction to be delivered.
logic  req_pending; // a request is out and its data not yet delivered.
logic  hold_valid;
inst_t hold_inst;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// redirect merge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

assign jump = eret.en | irq.en | ex_redirect.en | jal.en;

always_comb begin
    if (eret.en) begin
        jump_addr = eret.addr;
    end
    else if (irq.en) begin
        jump_addr = irq.addr;
    end
    else if (ex_redirect.en) begin
        jump_addr = ex_redirect.addr;
    end
    else begin
        jump_addr = jal.addr;
    end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory request side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        started <= 1'b0;
    end
    else begin
        started <= 1'b1;
    end
end

// a new request goes out when memory is idle and either nothing is pending
// or the pending word is being delivered right now.
assign imem_req  = started & ~imem_busy & ~jump & (fetch_valid | ~req_pending);
assign imem_addr = req_pc;

always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        req_pc <= reset_pc;
    end
    else if (jump) begin
        req_pc <= jump_addr;
    end
    else if (imem_req) begin
        req_pc <= req_pc + pc_step;
    end
end

always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        req_pending <= 1'b0;
    end
    else if (imem_req) begin
        req_pending <= 1'b1;
    end
    else if (fetch_valid | jump) begin
        req_pending <= 1'b0; // a stale read still finishes, its data is dropped.
    end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// delivery side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        hold_valid <= 1'b0;
    end
    else if (jump) begin
        hold_valid <= 1'b0;
    end
    else if (req_pending & stall & ~imem_busy) begin
        hold_valid <= 1'b1; // word arrived while decode was stalled.
    end
    else if (fetch_valid) begin
        hold_valid <= 1'b0;
    end
end

always_ff @(posedge clk) begin
    if (~imem_busy & ~hold_valid) begin
        hold_inst <= imem_rdata;
    end
end

always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        out_pc <= reset_pc;
    end
    else if (jump) begin
        out_pc <= jump_addr;
    end
    else if (fetch_valid) begin
        out_pc <= req_pc; // no request issues while held, so req_pc is the successor.
    end
end

assign fetch_valid = ((req_pending & ~imem_busy) | hold_valid) & ~stall & ~jump;
assign fetch.pc    = out_pc;
assign fetch.inst  = hold_valid ? hold_inst : imem_rdata;

endmodule

// File: jump_decode.sv
`timescale 1ns/1ps

module jump_decode (
    input  logic                  clk,
    input  logic                  rstn,
    input  fetch_pkg::fetch_out_t fetch,
    input  logic                  fetch_valid,
    output fetch_pkg::redirect_t  jal
);

import fetch_pkg::*;

logic  is_jal;
addr_t jal_imm;
addr_t jal_target;
logic  jal_en_q;
addr_t jal_addr_q;

assign is_jal = fetch_valid & (fetch.inst[6:0] == opcode_jal);

// J-type immediate is scattered over the word, bit 0 is always zero.
assign jal_imm = {
    {12{fetch.inst[31]}},
    fetch.inst[19:12],
    fetch.inst[20],
    fetch.inst[30:21],
    1'b0
};

assign jal_target = fetch.pc + jal_imm;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// registered redirect
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// the register keeps fetch_valid out of the ifu redirect path.
always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        jal_en_q <= 1'b0;
    end
    else begin
        jal_en_q <= is_jal;
    end
end

always_ff @(posedge clk) begin
    if (is_jal) begin
        jal_addr_q <= jal_target;
    end
end

assign jal.en   = jal_en_q;
assign jal.addr = jal_addr_q;

endmodule

// File: trap_ctrl.sv
`timescale 1ns/1ps

module trap_ctrl (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  irq_line,
    input  fetch_pkg::fetch_out_t fetch,
    input  logic                  fetch_valid,
    input  fetch_pkg::redirect_t  jal,
    input  fetch_pkg::redirect_t  ex_redirect,
    output fetch_pkg::redirect_t  eret,
    output fetch_pkg::redirect_t  irq
);

import fetch_pkg::*;

typedef enum logic [1:0] {
    run,
    in_handler,
    returning
} state_t;

state_t state;
state_t state_nxt;
logic   irq_q;    // registered copy of the external line.
logic   irq_en;   // interrupt enable.
logic   is_mret;
logic   take_irq;
addr_t  next_pc;  // where execution continues if nothing else happens.
addr_t  epc;

assign is_mret = fetch_valid & (fetch.inst == inst_mret);

// an interrupt never competes with another redirect in the same cycle.
assign take_irq = irq_q & irq_en & ~eret.en & ~jal.en & ~ex_redirect.en;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// trap sequencing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

always_comb begin
    state_nxt = state;
    case (state)
        run:        if (take_irq) state_nxt = in_handler;
                    else if (is_mret) state_nxt = returning;
        in_handler: if (is_mret) state_nxt = returning;
        returning:  state_nxt = run; // eret pulses for exactly this one cycle.
        default:    state_nxt = run;
    endcase
end

always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        state  <= run;
        irq_q  <= 1'b0;
        irq_en <= 1'b1;
    end
    else begin
        state <= state_nxt;
        irq_q <= irq_line;
        if (take_irq) begin
            irq_en <= 1'b0;
        end
        else if (state == returning) begin
            irq_en <= 1'b1;
        end
    end
end

// next_pc follows the redirect that ifu will pick, otherwise the last pc plus 4.
always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        next_pc <= reset_pc;
    end
    else if (eret.en) begin
        next_pc <= epc;
    end
    else if (take_irq) begin
        next_pc <= irq_vector;
    end
    else if (ex_redirect.en) begin
        next_pc <= ex_redirect.addr;
    end
    else if (jal.en) begin
        next_pc <= jal.addr;
    end
    else if (fetch_valid) begin
        next_pc <= fetch.pc + pc_step;
    end
end

always_ff @(posedge clk) begin
    if (take_irq) begin
        epc <= next_pc;
    end
end

assign eret.en  = (state == returning);
assign eret.addr = epc;
assign irq.en   = take_irq;
assign irq.addr = irq_vector;

endmodule

// File: fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  irq_line,
    input  fetch_pkg::redirect_t  ex_redirect,
    input  logic                  stall,
    output logic                  imem_req,
    output fetch_pkg::addr_t      imem_addr,
    input  fetch_pkg::inst_t      imem_rdata,
    input  logic                  imem_busy,
    output fetch_pkg::fetch_out_t fetch,
    output logic                  fetch_valid
);

import fetch_pkg::*;

redirect_t eret_rd;
redirect_t irq_rd;
redirect_t jal_rd;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

ifu ifu0 (
    .clk         (clk),
    .rstn        (rstn),
    .eret        (eret_rd),
    .irq         (irq_rd),
    .ex_redirect (ex_redirect),
    .jal         (jal_rd),
    .imem_req    (imem_req),
    .imem_addr   (imem_addr),
    .imem_rdata  (imem_rdata),
    .imem_busy   (imem_busy),
    .fetch       (fetch),
    .fetch_valid (fetch_valid),
    .stall       (stall)
);

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// watchers on the delivered stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

jump_decode jump_decode0 (
    .clk         (clk),
    .rstn        (rstn),
    .fetch       (fetch),
    .fetch_valid (fetch_valid),
    .jal         (jal_rd)
);

// trap_ctrl sees jal and ex_redirect to keep its next pc in step with ifu.
trap_ctrl trap_ctrl0 (
    .clk         (clk),
    .rstn        (rstn),
    .irq_line    (irq_line),
    .fetch       (fetch),
    .fetch_valid (fetch_valid),
    .jal         (jal_rd),
    .ex_redirect (ex_redirect),
    .eret        (eret_rd),
    .irq         (irq_rd)
);

endmodule

// File: tb_imem_model.sv
`timescale 1ns/1ps

module tb_imem_model (
    input  logic             clk,
    input  logic             rstn,
    input  logic             imem_req,
    input  fetch_pkg::addr_t imem_addr,
    output fetch_pkg::inst_t imem_rdata,
    output logic             imem_busy
);

import fetch_pkg::*;

localparam int mem_words = 1024;

inst_t mem [0:mem_words - 1];
int    jal_offsets [0:mem_words - 1]; // offset each JAL word was built from, zero elsewhere.
logic  pend;      // a read is in flight, stale or not.
int    wait_left; // busy cycles still to come before its data.
addr_t pend_addr;

// addi x1, x0 with the word index as immediate, so every word differs.
function automatic inst_t alu_word(logic [9:0] idx);
    return {2'b00, idx, 5'd0, 3'b000, 5'd1, 7'b001_0011};
endfunction

function automatic inst_t jal_word(int offset);
    logic [20:0] imm;
    imm = 21'(offset);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, opcode_jal};
endfunction

task automatic place(addr_t addr, inst_t word);
    mem[addr[11:2]] = word;
endtask

task automatic place_jal(addr_t addr, int offset);
    mem[addr[11:2]]         = jal_word(offset);
    jal_offsets[addr[11:2]] = offset;
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program image
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

initial begin
    for (int i = 0; i < mem_words; i++) begin
        mem[10'(i)]         = alu_word(10'(i));
        jal_offsets[10'(i)] = 0;
    end
    place_jal(32'h0000_0040, 128);   // forward into the block at 0x0c0.
    place_jal(32'h0000_00e0, -192);  // back to 0x020, closing the main loop.
    place(32'h0000_0110, inst_mret); // handler at irq_vector is five words long.
    place_jal(32'h0000_0220, -544);  // execute redirect targets return to 0x000.
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request and response timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
        pend      <= 1'b0;
        wait_left <= 0;
        pend_addr <= '0;
    end
    else if (imem_req) begin
        pend      <= 1'b1;
        pend_addr <= imem_addr;
        wait_left <= int'($urandom % 4);
    end
    else if (imem_busy) begin
        wait_left <= wait_left - 1;
    end
    else begin
        pend <= 1'b0; // the response cycle is over, taken or not.
    end
end

initial begin
    imem_busy  = 1'b0;
    imem_rdata = '0;
    forever begin
        @(negedge clk);
        imem_busy  = pend && (wait_left != 0);
        imem_rdata = (pend && wait_left == 0) ? mem[pend_addr[11:2]] : '0;
    end
end

endmodule

// File: tb_fetch_top.sv
`timescale 1ns/1ps

module tb_fetch_top;

import fetch_pkg::*;

localparam int n_insts     = 400;
localparam int mem_worst   = 4; // three busy cycles plus the response.
localparam int cycle_limit = 4 * n_insts * mem_worst;

logic       clk;
logic       rstn;
logic       irq_line;
logic       stall;
redirect_t  ex_redirect;
logic       imem_req;
addr_t      imem_addr;
inst_t      imem_rdata;
logic       imem_busy;
fetch_out_t fetch;
logic       fetch_valid;

// the reference model steps once per rising edge.
addr_t exp_pc;
addr_t req_exp;      // address the next memory request should carry.
addr_t cur_pc;
addr_t epc_m;
addr_t jal_tgt;
inst_t word;
int    jal_off;
logic  jal_seen;     // a JAL was delivered in the cycle just ended.
logic  mret_seen;
logic  jal_act;
logic  eret_act;
logic  irq_take;
logic  redir_act;
logic  irq_q_m;
logic  irq_en_m;
logic  in_handler_m;
logic  timed_out;

int errors       = 0;
int missed       = 0;
int delivered    = 0;
int after_reset  = 0;
int jal_fwd      = 0;
int jal_back     = 0;
int irq_entries  = 0;
int returns      = 0;
int irq_masked   = 0;
int stall_cycles = 0;
int ex_cnt       = 0;
int ex_over_jal  = 0;
int cycle_cnt    = 0;

fetch_top dut0 (
    .clk         (clk),
    .rstn        (rstn),
    .irq_line    (irq_line),
    .ex_redirect (ex_redirect),
    .stall       (stall),
    .imem_req    (imem_req),
    .imem_addr   (imem_addr),
    .imem_rdata  (imem_rdata),
    .imem_busy   (imem_busy),
    .fetch       (fetch),
    .fetch_valid (fetch_valid)
);

tb_imem_model imem0 (
    .clk        (clk),
    .rstn       (rstn),
    .imem_req   (imem_req),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .imem_busy  (imem_busy)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

task automatic compare_value(string name, logic [31:0] got, logic [31:0] want);
    assert (got == want) else begin
        $display("error: %s is %h, expected %h", name, got, want);
        errors++;
    end
endtask

task automatic expect_reached(logic reached, string what);
    assert (reached) else begin
        $display("not exercised: %s", what);
        missed++;
    end
endtask

task automatic pulse_ex_redirect();
    ex_redirect.en   = 1'b1;
    ex_redirect.addr = 32'h0000_0200 + 32'(4 * ($urandom % 4));
    ex_cnt++;
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference pc model and checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

always @(posedge clk) begin
    if (!rstn) begin
        exp_pc       = reset_pc;
        req_exp      = reset_pc;
        jal_seen     = 1'b0;
        mret_seen    = 1'b0;
        irq_q_m      = 1'b0;
        irq_en_m     = 1'b1;
        in_handler_m = 1'b0;
    end
    else begin
        after_reset++;
        if (after_reset == 1) begin
            compare_value("imem_req", 32'(imem_req), 32'h0);
        end
        if (stall) begin
            compare_value("fetch_valid", 32'(fetch_valid), 32'h0);
            stall_cycles++;
        end
        jal_act   = jal_seen;
        eret_act  = mret_seen;
        jal_seen  = 1'b0;
        mret_seen = 1'b0;
        irq_take  = irq_q_m && irq_en_m && !jal_act && !eret_act && !ex_redirect.en;
        redir_act = jal_act || eret_act || irq_take || ex_redirect.en;
        if (in_handler_m && irq_q_m) begin
            irq_masked++;
        end
        if (redir_act) begin
            compare_value("fetch_valid", 32'(fetch_valid), 32'h0); // redirects deliver nothing.
            compare_value("imem_req", 32'(imem_req), 32'h0);
        end
        if (eret_act) begin
            exp_pc       = epc_m;
            irq_en_m     = 1'b1;
            in_handler_m = 1'b0;
        end
        else if (irq_take) begin
            epc_m        = exp_pc;
            exp_pc       = irq_vector;
            irq_en_m     = 1'b0;
            in_handler_m = 1'b1;
            irq_entries++;
        end
        else if (ex_redirect.en) begin
            exp_pc = ex_redirect.addr;
        end
        else if (jal_act) begin
            exp_pc = jal_tgt;
        end
        else if (fetch_valid) begin
            cur_pc = exp_pc;
            word   = imem0.mem[cur_pc[11:2]];
            compare_value("fetch.pc", fetch.pc, cur_pc);
            compare_value("fetch.inst", fetch.inst, word);
            delivered++;
            exp_pc = cur_pc + 32'd4;
            if (word[6:0] == opcode_jal) begin
                jal_seen = 1'b1;
                jal_off  = imem0.jal_offsets[cur_pc[11:2]];
                jal_tgt  = cur_pc + addr_t'(jal_off);
                if (jal_off > 0) begin
                    jal_fwd++;
                end
                else begin
                    jal_back++;
                end
            end
            else if (word == inst_mret) begin
                mret_seen = 1'b1;
                returns++;
            end
        end
        // requests run on word by word from the last redirect target.
        if (redir_act) begin
            req_exp = exp_pc;
        end
        else if (imem_req) begin
            compare_value("imem_addr", imem_addr, req_exp);
            req_exp = req_exp + 32'd4;
        end
        irq_q_m = irq_line;
    end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stimulus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

initial begin
    void'($urandom(43));
    rstn        = 1'b0;
    irq_line    = 1'b0;
    stall       = 1'b0;
    ex_redirect = '0;
    repeat (16) @(negedge clk);
    rstn = 1'b1;
    while (delivered < n_insts && cycle_cnt < cycle_limit) begin
        @(negedge clk);
        cycle_cnt++;
        ex_redirect = '0;
        stall       = ($urandom % 8) == 0;
        irq_line    = (delivered % 100) >= 40 && (delivered % 100) < 48; // held across the handler.
        // an exit from the handler by ex_redirect would leave interrupts off for good.
        if (!in_handler_m && jal_seen && ($urandom % 3) == 0) begin
            pulse_ex_redirect();
            ex_over_jal++;
        end
        else if (!in_handler_m && ($urandom % 40) == 0) begin
            pulse_ex_redirect();
        end
    end
    timed_out = delivered < n_insts;
    if (timed_out) begin
        $display("timeout: %0d of %0d instructions delivered after %0d cycles",
                 delivered, n_insts, cycle_cnt);
    end
    expect_reached(jal_fwd > 0, "no JAL with a forward offset was delivered");
    expect_reached(jal_back > 0, "no JAL with a backward offset was delivered");
    expect_reached(ex_over_jal > 0, "ex_redirect never met a pending JAL pulse");
    expect_reached(irq_entries > 0, "no interrupt was taken");
    expect_reached(returns > 0, "no MRET was delivered");
    expect_reached(irq_masked > 0, "irq_line was never high inside the handler");
    expect_reached(stall_cycles > 0, "stall was never raised");
    $display("errors %0d, not exercised %0d, timeout %0d, delivered %0d, ex_redirect %0d",
             errors, missed, timed_out, delivered, ex_cnt);
    if (errors == 0 && missed == 0 && !timed_out) begin
        $display("Test completed successfully");
    end
    else begin
        $display("Test failed");
    end
    $finish;
end

endmodule

// File: src.f
fetch_pkg.sv
ifu.sv
jump_decode.sv
trap_ctrl.sv
fetch_top.sv
tb_imem_model.sv
tb_fetch_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up in the output.
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
